/* compile.f */
+incdir+include
hw/io_pkg.sv
hw/io_addr_decode.sv
hw/io_ready.sv
hw/io_port_fifo.sv
hw/io_access_ctrl.sv
hw/io_access_stage.sv
test/tb_clock_gen.sv
test/io_access_tb.sv

/* test/io_access_tb.sv */
// ############################
// I/O access stage testbench.
// Directed tests checked against a RAM and FIFO reference model.
// ############################

`timescale 1ns/1ps

`include "io_config.svh"

module io_access_tb;

    localparam int DEPTH       = `IO_FIFO_DEPTH;
    localparam int MIXED_STEPS = 40;
    localparam int OP_COUNT    = 16 + 6 + 4 + 12 + MIXED_STEPS;   // every operation takes 8 ns.
    localparam int LIMIT_NS    = 8 * OP_COUNT + 400;

    logic                      clock;
    logic                      rst_n;
    logic                      issue;
    io_pkg::io_addr_t          addr_a;
    io_pkg::io_addr_t          addr_b;
    io_pkg::io_addr_t          addr_w;
    io_pkg::io_word_t          write_data;
    logic [`IO_PORT_COUNT-1:0] in_push;
    io_pkg::io_word_t          in_data [`IO_PORT_COUNT];
    logic [`IO_PORT_COUNT-1:0] in_full;
    logic [`IO_PORT_COUNT-1:0] out_pop;
    io_pkg::io_word_t          out_data [`IO_PORT_COUNT];
    logic [`IO_PORT_COUNT-1:0] out_empty;
    io_pkg::io_word_t          operand_a;
    io_pkg::io_word_t          operand_b;
    logic                      done;
    logic                      annulled;

    // reference model of the RAM and of both FIFO directions.
    io_pkg::io_word_t ram_model [`IO_RAM_DEPTH];
    io_pkg::io_word_t in_q [`IO_PORT_COUNT][$];
    io_pkg::io_word_t out_q [`IO_PORT_COUNT][$];

    int error_count;
    int check_count;
    int test_count;
    int failed_tests;

    tb_clock_gen u_clock_gen (.clock(clock), .rst_n(rst_n));

    io_access_stage DUT (
        .clock(clock), .rst_n(rst_n), .issue(issue),
        .addr_a(addr_a), .addr_b(addr_b), .addr_w(addr_w), .write_data(write_data),
        .in_push(in_push), .in_data(in_data), .in_full(in_full),
        .out_pop(out_pop), .out_data(out_data), .out_empty(out_empty),
        .operand_a(operand_a), .operand_b(operand_b), .done(done), .annulled(annulled)
    );

    // bit 4 selects I/O, bit 0 picks the port and the low 4 bits pick a RAM word.
    function automatic bit is_io(input io_pkg::io_addr_t addr);
        return addr[`IO_ADDR_WIDTH-1];
    endfunction

    function automatic int port_of(input io_pkg::io_addr_t addr);
        return int'(addr[0]);
    endfunction

    function automatic int ram_of(input io_pkg::io_addr_t addr);
        return int'(addr[3:0]);
    endfunction

    function automatic io_pkg::io_addr_t rand_addr();
        if ($urandom_range(0, 2) == 0) begin
            return {1'b1, 3'b000, 1'($urandom_range(0, 1))};
        end
        return io_pkg::io_addr_t'($urandom_range(0, 15));
    endfunction

    task automatic check_word(input io_pkg::io_word_t got, input io_pkg::io_word_t exp,
                              input string what);
        check_count++;
        assert (got === exp) else begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        check_count++;
        assert (got === exp) else begin
            $display("mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            error_count++;
        end
    endtask

    // one instruction; the result is sampled at the falling edge after the commit edge.
    task automatic issue_op(input io_pkg::io_addr_t a, input io_pkg::io_addr_t b,
                            input io_pkg::io_addr_t w, input io_pkg::io_word_t data);
        io_pkg::io_addr_t src [2];
        io_pkg::io_word_t exp_op [2];
        bit               ready;
        src[0] = a;
        src[1] = b;
        ready  = 1'b1;
        for (int i = 0; i < 2; i++) begin
            if (is_io(src[i]) && in_q[port_of(src[i])].size() == 0) ready = 1'b0;
            if (!is_io(src[i])) exp_op[i] = ram_model[ram_of(src[i])];
            else if (in_q[port_of(src[i])].size() > 0) exp_op[i] = in_q[port_of(src[i])][0];
            else exp_op[i] = '0;
        end
        if (is_io(w) && out_q[port_of(w)].size() == DEPTH) ready = 1'b0;
        @(posedge clock);
        issue      <= 1'b1;
        addr_a     <= a;
        addr_b     <= b;
        addr_w     <= w;
        write_data <= data;
        @(posedge clock);
        issue <= 1'b0;
        @(negedge clock);
        check_bit(done, ready, "done");
        check_bit(annulled, !ready, "annulled");
        if (ready) begin
            check_word(operand_a, exp_op[0], "operand_a");
            check_word(operand_b, exp_op[1], "operand_b");
            // a port named twice gives up only one word.
            if (is_io(a)) void'(in_q[port_of(a)].pop_front());
            if (is_io(b) && !(is_io(a) && port_of(a) == port_of(b))) begin
                void'(in_q[port_of(b)].pop_front());
            end
            if (is_io(w)) out_q[port_of(w)].push_back(data);
            else ram_model[ram_of(w)] = data;
        end
    endtask

    task automatic push_input(input int p, input io_pkg::io_word_t data);
        check_bit(in_full[p], in_q[p].size() == DEPTH, "in_full");
        @(posedge clock);
        in_push[p] <= 1'b1;
        in_data[p] <= data;
        @(posedge clock);
        in_push[p] <= 1'b0;
        @(negedge clock);
        in_q[p].push_back(data);
    endtask

    task automatic pop_output(input int p);
        check_bit(out_empty[p], out_q[p].size() == 0, "out_empty");
        if (out_q[p].size() > 0) check_word(out_data[p], out_q[p][0], "out_data");
        @(posedge clock);
        out_pop[p] <= 1'b1;
        @(posedge clock);
        out_pop[p] <= 1'b0;
        @(negedge clock);
        void'(out_q[p].pop_front());
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("%s: ok", name);
        end else begin
            failed_tests++;
            $display("%s: %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic ram_roundtrip();
        int errors_before;
        errors_before = error_count;
        for (int i = 0; i < 8; i++) begin
            issue_op(rand_addr() & 5'h0f, rand_addr() & 5'h0f, 5'(i), 16'($urandom));
        end
        for (int i = 0; i < 8; i++) begin
            issue_op(5'(i), 5'(7 - i), 5'(8 + i), 16'($urandom));
        end
        finish_test("ram_roundtrip", errors_before);
    endtask

    task automatic io_read_order();
        int errors_before;
        errors_before = error_count;
        push_input(0, 16'($urandom));
        push_input(0, 16'($urandom));
        issue_op(5'h10, 5'h11, 5'h03, 16'($urandom));   // port 1 is empty, so annulled.
        push_input(1, 16'($urandom));
        issue_op(5'h10, 5'h11, 5'h03, 16'($urandom));
        issue_op(5'h10, 5'h02, 5'h04, 16'($urandom));   // second word of port 0.
        finish_test("io_read_order", errors_before);
    endtask

    task automatic same_port_read();
        int errors_before;
        errors_before = error_count;
        push_input(1, 16'($urandom));
        push_input(1, 16'($urandom));
        issue_op(5'h11, 5'h11, 5'h05, 16'($urandom));
        issue_op(5'h11, 5'h00, 5'h06, 16'($urandom));
        finish_test("same_port_read", errors_before);
    endtask

    task automatic output_backpressure();
        int errors_before;
        errors_before = error_count;
        for (int i = 0; i < DEPTH; i++) begin
            issue_op(5'(i), 5'(i + 1), 5'h10, 16'($urandom));
        end
        push_input(1, 16'($urandom));
        issue_op(5'h11, 5'h02, 5'h10, 16'($urandom));   // output 0 is full.
        pop_output(0);
        issue_op(5'h11, 5'h02, 5'h10, 16'($urandom));
        for (int i = 0; i < DEPTH; i++) begin
            pop_output(0);
        end
        check_bit(out_empty[0], 1'b1, "out_empty after drain");
        finish_test("output_backpressure", errors_before);
    endtask

    task automatic mixed_stream();
        int errors_before;
        int kind;
        int p;
        errors_before = error_count;
        for (int n = 0; n < MIXED_STEPS; n++) begin
            kind = $urandom_range(0, 2);
            p    = $urandom_range(0, `IO_PORT_COUNT - 1);
            // pushes and pops only where the FIFO rules allow them.
            if (kind == 0 && in_q[p].size() < DEPTH) begin
                push_input(p, 16'($urandom));
            end else if (kind == 1 && out_q[p].size() > 0) begin
                pop_output(p);
            end else begin
                issue_op(rand_addr(), rand_addr(), rand_addr(), 16'($urandom));
            end
        end
        finish_test("mixed_stream", errors_before);
    endtask

    initial begin
        #(LIMIT_NS);
        $display("timeout: the run did not finish within %0d ns", LIMIT_NS);
        $display("Test failed");
        $finish;
    end

    initial begin
        void'($urandom(32'hfa86));
        issue      = 1'b0;
        addr_a     = '0;
        addr_b     = '0;
        addr_w     = '0;
        write_data = '0;
        in_push    = '0;
        out_pop    = '0;
        for (int p = 0; p < `IO_PORT_COUNT; p++) begin
            in_data[p] = '0;
        end
        for (int k = 0; k < `IO_RAM_DEPTH; k++) begin
            ram_model[k] = '0;
        end
        error_count  = 0;
        check_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        wait (rst_n === 1'b1);
        @(negedge clock);
        check_bit(done, 1'b0, "done after reset");
        check_bit(annulled, 1'b0, "annulled after reset");
        check_bit(&out_empty, 1'b1, "out_empty after reset");
        check_bit(|in_full, 1'b0, "in_full after reset");
        ram_roundtrip();
        io_read_order();
        same_port_read();
        output_backpressure();
        mixed_stream();
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* test/tb_clock_gen.sv */
// ############################
// Testbench clock and reset.
// ############################

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;   // 4 ns period.
    end

    // reset is held low for the first four rising edges.
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clock);
        rst_n <= 1'b1;
    end

endmodule

/* hw/io_access_stage.sv */
// ############################
// I/O access stage top level.
// Decoder, ready check, controller and the per-port FIFOs.
// ############################

`timescale 1ns/1ps

`include "io_config.svh"

module io_access_stage (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          issue,
    input  io_pkg::io_addr_t              addr_a,
    input  io_pkg::io_addr_t              addr_b,
    input  io_pkg::io_addr_t              addr_w,
    input  io_pkg::io_word_t              write_data,
    input  logic [`IO_PORT_COUNT-1:0]     in_push,
    input  io_pkg::io_word_t              in_data [`IO_PORT_COUNT],
    output logic [`IO_PORT_COUNT-1:0]     in_full,
    input  logic [`IO_PORT_COUNT-1:0]     out_pop,
    output io_pkg::io_word_t              out_data [`IO_PORT_COUNT],
    output logic [`IO_PORT_COUNT-1:0]     out_empty,
    output io_pkg::io_word_t              operand_a,
    output io_pkg::io_word_t              operand_b,
    output logic                          done,
    output logic                          annulled
);

    logic [`IO_READ_OPERANDS-1:0] read_is_io;
    logic                         write_is_io;
    io_pkg::port_idx_t            read_port [`IO_READ_OPERANDS];
    io_pkg::port_idx_t            write_port;
    io_pkg::ram_idx_t             read_ram_idx [`IO_READ_OPERANDS];
    io_pkg::ram_idx_t             write_ram_idx;
    logic [`IO_READ_OPERANDS-1:0] read_ef;
    logic                         write_ef;
    logic                         all_io_ready;
    logic [`IO_PORT_COUNT-1:0]    in_empty;
    logic [`IO_PORT_COUNT-1:0]    in_pop;
    io_pkg::io_word_t             in_head [`IO_PORT_COUNT];
    logic [`IO_PORT_COUNT-1:0]    out_full;
    logic [`IO_PORT_COUNT-1:0]    out_push;
    io_pkg::io_word_t             out_push_data;

    io_addr_decode u_decode (
        .addr_a        (addr_a),
        .addr_b        (addr_b),
        .addr_w        (addr_w),
        .read_is_io    (read_is_io),
        .write_is_io   (write_is_io),
        .read_port     (read_port),
        .write_port    (write_port),
        .read_ram_idx  (read_ram_idx),
        .write_ram_idx (write_ram_idx)
    );

    // combinational ready, so commit happens at the edge that samples issue.
    io_ready #(
        .READ_PORT_COUNT  (`IO_READ_OPERANDS),
        .WRITE_PORT_COUNT (1),
        .REGISTERED       (1'b0)
    ) u_ready (
        .clock        (clock),
        .rst_n        (rst_n),
        .read_is_io   (read_is_io),
        .write_is_io  (write_is_io),
        .read_ef      (read_ef),
        .write_ef     (write_ef),
        .all_io_ready (all_io_ready)
    );

    io_access_ctrl u_ctrl (
        .clock         (clock),
        .rst_n         (rst_n),
        .issue         (issue),
        .write_data    (write_data),
        .read_is_io    (read_is_io),
        .write_is_io   (write_is_io),
        .read_port     (read_port),
        .write_port    (write_port),
        .read_ram_idx  (read_ram_idx),
        .write_ram_idx (write_ram_idx),
        .all_io_ready  (all_io_ready),
        .in_empty      (in_empty),
        .in_head       (in_head),
        .out_full      (out_full),
        .read_ef       (read_ef),
        .write_ef      (write_ef),
        .in_pop        (in_pop),
        .out_push      (out_push),
        .out_push_data (out_push_data),
        .operand_a     (operand_a),
        .operand_b     (operand_b),
        .done          (done),
        .annulled      (annulled)
    );

    generate
        for (genvar p = 0; p < `IO_PORT_COUNT; p++) begin : g_port
            // filled from outside, drained by committing reads.
            io_port_fifo u_in_fifo (
                .clock     (clock),
                .rst_n     (rst_n),
                .push      (in_push[p]),
                .push_data (in_data[p]),
                .pop       (in_pop[p]),
                .head_data (in_head[p]),
                .empty     (in_empty[p]),
                .full      (in_full[p])
            );

            // filled by committing writes, drained from outside.
            io_port_fifo u_out_fifo (
                .clock     (clock),
                .rst_n     (rst_n),
                .push      (out_push[p]),
                .push_data (out_push_data),
                .pop       (out_pop[p]),
                .head_data (out_data[p]),
                .empty     (out_empty[p]),
                .full      (out_full[p])
            );
        end
    endgenerate

endmodule

/* hw/io_access_ctrl.sv */
// ############################
// I/O access controller.
// Owns the data RAM, picks operands, and commits or annuls each issue.
// ############################

`timescale 1ns/1ps

`include "io_config.svh"

module io_access_ctrl (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          issue,
    input  io_pkg::io_word_t              write_data,
    input  logic [`IO_READ_OPERANDS-1:0]  read_is_io,
    input  logic                          write_is_io,
    input  io_pkg::port_idx_t             read_port [`IO_READ_OPERANDS],
    input  io_pkg::port_idx_t             write_port,
    input  io_pkg::ram_idx_t              read_ram_idx [`IO_READ_OPERANDS],
    input  io_pkg::ram_idx_t              write_ram_idx,
    input  logic                          all_io_ready,
    input  logic [`IO_PORT_COUNT-1:0]     in_empty,
    input  io_pkg::io_word_t              in_head [`IO_PORT_COUNT],
    input  logic [`IO_PORT_COUNT-1:0]     out_full,
    output logic [`IO_READ_OPERANDS-1:0]  read_ef,
    output logic                          write_ef,
    output logic [`IO_PORT_COUNT-1:0]     in_pop,
    output logic [`IO_PORT_COUNT-1:0]     out_push,
    output io_pkg::io_word_t              out_push_data,
    output io_pkg::io_word_t              operand_a,
    output io_pkg::io_word_t              operand_b,
    output logic                          done,
    output logic                          annulled
);

    io_pkg::io_word_t ram [`IO_RAM_DEPTH];
    io_pkg::io_word_t source [`IO_READ_OPERANDS];
    logic             commit;
    logic             ram_we;

    // per-operand flags for the ready check, looked up by decoded port.
    always_comb begin
        for (int i = 0; i < `IO_READ_OPERANDS; i++) begin
            read_ef[i] = !in_empty[read_port[i]];
        end
    end
    assign write_ef = out_full[write_port];

    assign commit = issue && all_io_ready;
    assign ram_we = commit && !write_is_io;

    // each operand comes from the RAM or from the head of its input port.
    always_comb begin
        for (int i = 0; i < `IO_READ_OPERANDS; i++) begin
            source[i] = read_is_io[i] ? in_head[read_port[i]] : ram[read_ram_idx[i]];
        end
    end

    // a port named by both sources is popped once, and both see its head.
    always_comb begin
        in_pop   = '0;
        out_push = '0;
        for (int p = 0; p < `IO_PORT_COUNT; p++) begin
            for (int i = 0; i < `IO_READ_OPERANDS; i++) begin
                if (commit && read_is_io[i] && read_port[i] == io_pkg::port_idx_t'(p)) begin
                    in_pop[p] = 1'b1;
                end
            end
            out_push[p] = commit && write_is_io && write_port == io_pkg::port_idx_t'(p);
        end
    end

    assign out_push_data = write_data;   // only consumed where out_push is set.

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < `IO_RAM_DEPTH; k++) begin
                ram[k] <= '0;
            end
        end else if (ram_we) begin
            ram[write_ram_idx] <= write_data;
        end
    end

    // operands are captured only for an instruction that commits.
    always_ff @(posedge clock) begin
        if (commit) begin
            operand_a <= source[0];
            operand_b <= source[1];
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            done     <= 1'b0;
            annulled <= 1'b0;
        end else begin
            done     <= commit;
            annulled <= issue && !all_io_ready;   // has no side effect so the thread can replay.
        end
    end

    // the ready check must keep pushes away from full output ports.
    a_push_has_room: assert property (@(posedge clock) disable iff (!rst_n)
        !(|(out_push & out_full)))
        else $error("output port pushed while full");

    // the ready check must keep pops away from empty input ports.
    a_pop_has_data: assert property (@(posedge clock) disable iff (!rst_n)
        !(|(in_pop & in_empty)))
        else $error("input port popped while empty");

endmodule

/* hw/io_port_fifo.sv */
// ############################
// Port FIFO.
// Small first-word-fall-through buffer for one I/O port direction.
// ############################

`timescale 1ns/1ps

`include "io_config.svh"

module io_port_fifo (
    input  logic             clock,
    input  logic             rst_n,
    input  logic             push,
    input  io_pkg::io_word_t push_data,
    input  logic             pop,
    output io_pkg::io_word_t head_data,
    output logic             empty,
    output logic             full
);

    localparam int DEPTH   = `IO_FIFO_DEPTH;
    localparam int PTR_W   = $clog2(DEPTH);
    localparam int COUNT_W = $clog2(DEPTH + 1);

    io_pkg::io_word_t   mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [COUNT_W-1:0] count;
    logic               do_push;
    logic               do_pop;

    assign empty = (count == '0);
    assign full  = (count == COUNT_W'(DEPTH));

    // illegal requests are dropped so the pointers stay consistent.
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign head_data = mem[rd_ptr];   // the head falls through with no read latency.

    always_ff @(posedge clock) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // a push and a pop in the same cycle leave the count alone.
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    a_no_push_full: assert property (@(posedge clock) disable iff (!rst_n) push |-> !full)
        else $error("push into a full port FIFO");

    a_no_pop_empty: assert property (@(posedge clock) disable iff (!rst_n) pop |-> !empty)
        else $error("pop from an empty port FIFO");

endmodule

/* hw/io_ready.sv */
// ############################
// I/O ready check.
// Ready when every I/O source has data and every I/O destination has room.
// ############################

`timescale 1ns/1ps

module io_ready #(
    parameter int READ_PORT_COUNT  = 2,
    parameter int WRITE_PORT_COUNT = 1,
    parameter bit REGISTERED       = 1'b0
) (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic [READ_PORT_COUNT-1:0]  read_is_io,
    input  logic [WRITE_PORT_COUNT-1:0] write_is_io,
    input  logic [READ_PORT_COUNT-1:0]  read_ef,      // 1 when the source FIFO holds data.
    input  logic [WRITE_PORT_COUNT-1:0] write_ef,     // 1 when the destination FIFO is full.
    output logic                        all_io_ready
);

    logic [READ_PORT_COUNT-1:0]  read_ef_masked;
    logic [WRITE_PORT_COUNT-1:0] write_ef_masked;
    logic                        ready_comb;

    // a RAM operand never waits, so its flag is forced to the ready value.
    always_comb begin
        for (int i = 0; i < READ_PORT_COUNT; i++) begin
            read_ef_masked[i] = read_is_io[i] ? read_ef[i] : 1'b1;
        end
        for (int j = 0; j < WRITE_PORT_COUNT; j++) begin
            write_ef_masked[j] = write_is_io[j] ? write_ef[j] : 1'b0;
        end
    end

    assign ready_comb = (&read_ef_masked) & ~(|write_ef_masked);

    generate
        if (REGISTERED) begin : g_registered
            // adds one cycle of latency to the ready decision.
            always_ff @(posedge clock or negedge rst_n) begin
                if (!rst_n) begin
                    all_io_ready <= 1'b0;
                end else begin
                    all_io_ready <= ready_comb;
                end
            end
        end else begin : g_comb
            assign all_io_ready = ready_comb;
        end
    endgenerate

endmodule

/* hw/io_addr_decode.sv */
// ############################
// Operand address decoder.
// Splits each address into an I/O flag, a port and a RAM index.
// ############################

`timescale 1ns/1ps

`include "io_config.svh"

module io_addr_decode (
    input  io_pkg::io_addr_t                  addr_a,
    input  io_pkg::io_addr_t                  addr_b,
    input  io_pkg::io_addr_t                  addr_w,
    output logic [`IO_READ_OPERANDS-1:0]      read_is_io,
    output logic                              write_is_io,
    output io_pkg::port_idx_t                 read_port [`IO_READ_OPERANDS],
    output io_pkg::port_idx_t                 write_port,
    output io_pkg::ram_idx_t                  read_ram_idx [`IO_READ_OPERANDS],
    output io_pkg::ram_idx_t                  write_ram_idx
);

    localparam int IO_SEL_BIT = `IO_ADDR_WIDTH - 1;     // bit 4 of a 5-bit address.
    localparam int PORT_BITS  = $bits(io_pkg::port_idx_t);
    localparam int RAM_BITS   = $bits(io_pkg::ram_idx_t);

    io_pkg::io_addr_t read_addr [`IO_READ_OPERANDS];

    // the two sources are decoded the same way, so gather them in an array.
    assign read_addr[0] = addr_a;
    assign read_addr[1] = addr_b;

    always_comb begin
        for (int i = 0; i < `IO_READ_OPERANDS; i++) begin
            read_is_io[i]   = read_addr[i][IO_SEL_BIT];
            read_port[i]    = read_addr[i][PORT_BITS-1:0];   // low bits pick the port.
            read_ram_idx[i] = read_addr[i][RAM_BITS-1:0];
        end
    end

    // the destination follows the same map as the sources.
    assign write_is_io   = addr_w[IO_SEL_BIT];
    assign write_port    = addr_w[PORT_BITS-1:0];
    assign write_ram_idx = addr_w[RAM_BITS-1:0];

endmodule

/* hw/io_pkg.sv */
// ############################
// I/O access stage types.
// Word, address and index types shared by the stage.
// ############################

`include "io_config.svh"

package io_pkg;

    // one data word, as held in RAM and in every port FIFO.
    typedef logic [`IO_WORD_WIDTH-1:0] io_word_t;

    // operand address; the top bit selects I/O over RAM.
    typedef logic [`IO_ADDR_WIDTH-1:0] io_addr_t;

    // selects one of the I/O ports.
    typedef logic [$clog2(`IO_PORT_COUNT)-1:0] port_idx_t;

    // selects one word of the data RAM.
    typedef logic [$clog2(`IO_RAM_DEPTH)-1:0] ram_idx_t;

endpackage

/* include/io_config.svh */
// ############################
// I/O access stage configuration.
// Sizes of words, addresses, ports, FIFOs and the data RAM.
// ############################

`ifndef IO_CONFIG_SVH
`define IO_CONFIG_SVH

// data path and operand addressing.
`define IO_WORD_WIDTH     16
`define IO_ADDR_WIDTH     5

// port FIFOs, one input and one output per port.
`define IO_PORT_COUNT     2
`define IO_FIFO_DEPTH     4

`define IO_RAM_DEPTH      16
`define IO_READ_OPERANDS  2

`endif
